// File: list.f
+incdir+src
src/noc_router_pkg.sv
src/input_port.sv
src/switch_allocator.sv
src/crossbar.sv
src/credit_release_gen.sv
src/router_two_stage.sv
sim/router_chk.sv
sim/router_tb.sv

// File: Bender.yml
package:
  name: noc_router

sources:
  - include_dirs:
      - src
    files:
      - src/noc_router_pkg.sv
      - src/input_port.sv
      - src/switch_allocator.sv
      - src/crossbar.sv
      - src/credit_release_gen.sv
      - src/router_two_stage.sv

  - target: simulation
    include_dirs:
      - src
    files:
      - sim/router_chk.sv
      - sim/router_tb.sv

// File: sim/router_tb.sv
`include "noc_router_macros.svh"

module router_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import noc_router_pkg::*;

    localparam int RAND_PKTS   = 12;
    localparam int HOLD_CYCLES = 40;
    localparam int STIM_CYCLES = 2 * `NOC_PORTS * RAND_PKTS * 4 + 4 * `NOC_PORTS * 8 + HOLD_CYCLES;

    logic         clk = 1'b0;
    logic         arst_n;
    router_addr_t router_addr;
    flit_chan_t   chan_in  [`NOC_PORTS];
    flit_chan_t   chan_out [`NOC_PORTS];
    port_oh_t     credit_release_en;

    logic [15:0]  lfsr = 16'd39955;
    int           pkts_left  [`NOC_PORTS];
    int           flits_left [`NOC_PORTS];
    int           pkt_len    [`NOC_PORTS];
    int           gap        [`NOC_PORTS];
    int           up_crd     [`NOC_PORTS];  // free slots in each input buffer
    int           rel_left   [`NOC_PORTS];  // release credits still to come
    int           sent       [`NOC_PORTS];
    int           crd_back   [`NOC_PORTS];
    int           bursts     [`NOC_PORTS];
    router_addr_t cur_dst    [`NOC_PORTS];
    logic [12:0]  seq        [`NOC_PORTS];
    int           ret_due    [`NOC_PORTS][$];   // cycle when each credit goes back
    int           sent_total = 0;
    int           recv_total = 0;
    int           cyc = 0;
    logic         hold = 1'b0;                  // withhold downstream credits
    logic         single_only = 1'b0;
    logic         cons_ok;

    router_two_stage router_two_stage_inst (
        .clk              (clk),
        .arst_n           (arst_n),
        .router_addr      (router_addr),
        .chan_in          (chan_in),
        .chan_out         (chan_out),
        .credit_release_en(credit_release_en)
    );

    always #50 clk = ~clk;

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] rand_bits(int n);
        logic [15:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[14:0], lfsr[0]};
        end
        return r;
    endfunction

    // all input buffers empty again and no credit still owed downstream
    function automatic bit drained();
        bit d;
        d = 1'b1;
        for (int i = 0; i < `NOC_PORTS; i++) begin
            d &= (pkts_left[i] == 0) && (flits_left[i] == 0) && (rel_left[i] == 0);
            d &= (up_crd[i] >= `NOC_BUF_DEPTH) && (ret_due[i].size() == 0);
        end
        return d;
    endfunction

    task automatic wait_drained();
        do @(negedge clk); while (!drained());
        repeat (3) @(negedge clk);
    endtask

    // upstream senders and downstream credit return
    always @(posedge clk) begin : traffic
        flit_t       f;
        logic [15:0] r;
        if (arst_n) begin
            cyc++;
            for (int o = 0; o < `NOC_PORTS; o++) begin
                if (chan_out[o].flit_wr) begin
                    recv_total++;
                    ret_due[o].push_back(cyc + 1 + int'(rand_bits(3)));
                end
                if (!hold && ret_due[o].size() > 0 && ret_due[o][0] <= cyc) begin
                    void'(ret_due[o].pop_front());
                    chan_in[o].credit <= 1'b1;
                end else begin
                    chan_in[o].credit <= 1'b0;
                end
            end
            for (int i = 0; i < `NOC_PORTS; i++) begin
                if (credit_release_en[i]) begin
                    rel_left[i] += `NOC_BUF_DEPTH;
                    bursts[i]++;
                end
                if (chan_out[i].credit) begin
                    crd_back[i]++;
                    if (rel_left[i] > 0) begin
                        rel_left[i]--;
                    end else begin
                        up_crd[i]++;
                    end
                end
                chan_in[i].flit_wr <= 1'b0;
                if (gap[i] > 0) begin
                    gap[i]--;
                end else if (up_crd[i] > 0 && (flits_left[i] > 0 || pkts_left[i] > 0)) begin
                    if (flits_left[i] == 0) begin
                        r             = rand_bits(6);
                        cur_dst[i]    = r[5:0];
                        pkt_len[i]    = single_only ? 1 : 1 + int'(rand_bits(2));
                        flits_left[i] = pkt_len[i];
                        pkts_left[i]--;
                    end
                    if (pkt_len[i] == 1) f.flit_type = SINGLE;
                    else if (flits_left[i] == pkt_len[i]) f.flit_type = HEAD;
                    else if (flits_left[i] == 1) f.flit_type = TAIL;
                    else f.flit_type = BODY;
                    f.dst     = cur_dst[i];
                    f.payload = {3'(i), seq[i]};    // source port and sequence
                    seq[i]++;
                    flits_left[i]--;
                    up_crd[i]--;
                    sent[i]++;
                    sent_total++;
                    chan_in[i].flit    <= f;
                    chan_in[i].flit_wr <= 1'b1;
                    if (flits_left[i] == 0) gap[i] = int'(rand_bits(2));
                end
            end
        end
    end

    always @(posedge clk) begin
        if (router_two_stage_inst.router_chk_inst.chk_fail) begin
            $display("FAIL %s expected %0h actual %0h",
                     router_two_stage_inst.router_chk_inst.chk_name,
                     router_two_stage_inst.router_chk_inst.chk_exp,
                     router_two_stage_inst.router_chk_inst.chk_act);
            $display("Regression failed");
            $fatal(1, "stopped at the first failed check");
        end
    end

    initial begin
        #(STIM_CYCLES * 10 * 100);
        $display("the run hung and traffic did not drain within the time limit");
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        arst_n            = 1'b0;
        router_addr       = '{x: 3'd2, y: 3'd2};
        credit_release_en = '0;
        for (int i = 0; i < `NOC_PORTS; i++) begin
            chan_in[i] = '0;
            {pkts_left[i], flits_left[i], pkt_len[i], gap[i]} = '0;
            {rel_left[i], sent[i], crd_back[i], bursts[i]} = '0;
            up_crd[i] = `NOC_BUF_DEPTH;
            seq[i]    = '0;
        end
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(negedge clk);

        // lone single flits, one port at a time
        single_only = 1'b1;
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < `NOC_PORTS; i++) begin
                pkts_left[i] = 1;
                wait_drained();
            end
        end
        single_only = 1'b0;

        for (int i = 0; i < `NOC_PORTS; i++) begin
            @(posedge clk);
            credit_release_en[i] <= 1'b1;
            @(posedge clk);
            credit_release_en <= '0;
            repeat (8) @(posedge clk);
        end
        wait_drained();

        for (int i = 0; i < `NOC_PORTS; i++) pkts_left[i] = RAND_PKTS;
        wait_drained();

        // back-pressure phase
        hold = 1'b1;
        for (int i = 0; i < `NOC_PORTS; i++) pkts_left[i] = RAND_PKTS;
        repeat (HOLD_CYCLES) @(negedge clk);
        hold = 1'b0;
        wait_drained();

        cons_ok = 1'b1;
        for (int i = 0; i < `NOC_PORTS; i++) begin
            if (cons_ok && crd_back[i] != sent[i] + bursts[i] * `NOC_BUF_DEPTH) begin
                $display("FAIL conservation port %0d expected %0d actual %0d",
                         i, sent[i] + bursts[i] * `NOC_BUF_DEPTH, crd_back[i]);
                cons_ok = 1'b0;
            end
        end
        if (cons_ok && recv_total != sent_total) begin
            $display("FAIL conservation flits expected %0d actual %0d", sent_total, recv_total);
            cons_ok = 1'b0;
        end
        if (!cons_ok) begin
            $display("Regression failed");
            $fatal(1, "flit or credit count mismatch");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// File: sim/router_chk.sv
`include "noc_router_macros.svh"

module router_chk (
    input logic                                clk,
    input logic                                arst_n,
    input noc_router_pkg::router_addr_t        router_addr,
    input noc_router_pkg::flit_chan_t          chan_in  [`NOC_PORTS],
    input noc_router_pkg::flit_chan_t          chan_out [`NOC_PORTS],
    input noc_router_pkg::port_oh_t            credit_release_en
);
    timeunit 1ns;
    timeprecision 1ps;
    import noc_router_pkg::*;

    logic        chk_fail = 1'b0;   // watched by the testbench
    string       chk_name = "";
    logic [31:0] chk_exp  = '0;
    logic [31:0] chk_act  = '0;

    logic [`NOC_PORTS-1:0] in_wr;
    logic [`NOC_PORTS-1:0] out_wr;
    logic [`NOC_PORTS-1:0] out_crd;
    logic [`NOC_PORTS-1:0] in_open;     // input in the middle of a packet
    logic [`NOC_PORTS-1:0] rel_used;    // release burst already spent
    logic [`NOC_PORTS-1:0] exp_v1;
    logic [`NOC_PORTS-1:0] exp_v2;
    logic [`NOC_PORTS-1:0] route_ok;
    logic [`NOC_PORTS-1:0] pkt_open;    // per output
    port_e                 exp_o1   [`NOC_PORTS];
    port_e                 exp_o2   [`NOC_PORTS];
    flit_t                 exp_f1   [`NOC_PORTS];
    flit_t                 exp_f2   [`NOC_PORTS];
    logic [15:0]           exp_pay  [`NOC_PORTS];
    logic [2:0]            last_src [`NOC_PORTS];
    logic [12:0]           last_seq [`NOC_PORTS];
    int                    crdt     [`NOC_PORTS];   // downstream slots per output
    int                    in_flight;

    task automatic record_failure(string name, logic [31:0] e, logic [31:0] a);
        chk_name = name;
        chk_exp  = e;
        chk_act  = a;
        chk_fail = 1'b1;
    endtask

    // x first, then y
    function automatic port_e xy_route(router_addr_t dst, router_addr_t here);
        if (dst.x > here.x) return EAST;
        if (dst.x < here.x) return WEST;
        if (dst.y > here.y) return NORTH;
        if (dst.y < here.y) return SOUTH;
        return LOCAL;
    endfunction

    always_comb begin
        for (int p = 0; p < `NOC_PORTS; p++) begin
            in_wr[p]    = chan_in[p].flit_wr;
            out_wr[p]   = chan_out[p].flit_wr;
            out_crd[p]  = chan_out[p].credit;
            route_ok[p] = chan_out[exp_o2[p]].flit_wr
                       && (chan_out[exp_o2[p]].flit == exp_f2[p])
                       && chan_out[p].credit;
            exp_pay[p]  = {last_src[p], last_seq[p] + 13'd1};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_flight <= 0;
            in_open   <= '0;
            rel_used  <= '0;
            exp_v1    <= '0;
            exp_v2    <= '0;
            pkt_open  <= '0;
            for (int p = 0; p < `NOC_PORTS; p++) begin
                crdt[p]     <= `NOC_BUF_DEPTH;
                last_src[p] <= '0;
                last_seq[p] <= '0;
            end
        end else begin
            in_flight <= in_flight + $countones(in_wr) - $countones(out_wr);
            rel_used  <= rel_used | credit_release_en;
            exp_v2    <= exp_v1;
            exp_o2    <= exp_o1;
            exp_f2    <= exp_f1;
            for (int p = 0; p < `NOC_PORTS; p++) begin
                crdt[p] <= crdt[p] + int'(chan_in[p].credit) - int'(out_wr[p]);
                if (in_wr[p]) begin
                    in_open[p] <= chan_in[p].flit.flit_type inside {HEAD, BODY};
                end
                // lone single flit into an empty router
                exp_v1[p] <= in_wr[p] && (chan_in[p].flit.flit_type == SINGLE)
                          && (in_flight == 0) && ($countones(in_wr) == 1)
                          && (in_open == '0)
                          && (crdt[xy_route(chan_in[p].flit.dst, router_addr)] != 0);
                exp_o1[p] <= xy_route(chan_in[p].flit.dst, router_addr);
                exp_f1[p] <= chan_in[p].flit;
                if (out_wr[p]) begin
                    pkt_open[p] <= chan_out[p].flit.flit_type inside {HEAD, BODY};
                    last_src[p] <= chan_out[p].flit.payload[15:13];
                    last_seq[p] <= chan_out[p].flit.payload[12:0];
                end
            end
        end
    end

    a_reset: assert property (@(posedge clk)
        (!arst_n || $rose(arst_n)) |-> (out_wr == '0 && out_crd == '0))
        else begin
            $error("outputs active around reset");
            record_failure("reset", 0, {out_wr, out_crd});
        end

    for (genvar p = 0; p < `NOC_PORTS; p++) begin : g_chk
        a_route: assert property (@(posedge clk) disable iff (!arst_n)
            exp_v2[p] |-> route_ok[p])
            else begin
                $error("single flit not routed on time");
                record_failure("uncontended routing", exp_f2[p], chan_out[exp_o2[p]].flit);
            end

        a_no_credit: assert property (@(posedge clk) disable iff (!arst_n)
            out_wr[p] |-> crdt[p] != 0)
            else begin
                $error("flit sent without downstream credit");
                record_failure("credit back-pressure", 1, crdt[p]);
            end

        a_crdt_max: assert property (@(posedge clk) disable iff (!arst_n)
            crdt[p] <= `NOC_BUF_DEPTH)
            else begin
                $error("downstream credit above buffer depth");
                record_failure("credit overflow", `NOC_BUF_DEPTH, crdt[p]);
            end

        a_body: assert property (@(posedge clk) disable iff (!arst_n)
            out_wr[p] && (chan_out[p].flit.flit_type inside {BODY, TAIL})
            |-> pkt_open[p] && (chan_out[p].flit.payload == exp_pay[p]))
            else begin
                $error("packet interleaved on output");
                record_failure("packet atomicity", exp_pay[p], chan_out[p].flit.payload);
            end

        a_head: assert property (@(posedge clk) disable iff (!arst_n)
            out_wr[p] && (chan_out[p].flit.flit_type inside {HEAD, SINGLE}) |-> !pkt_open[p])
            else begin
                $error("head flit inside an open packet");
                record_failure("packet atomicity head", 0, pkt_open[p]);
            end

        a_release: assert property (@(posedge clk) disable iff (!arst_n)
            credit_release_en[p] && !rel_used[p] && (in_flight == 0) && (in_wr == '0)
            |-> ##1 out_crd[p] [*`NOC_BUF_DEPTH] ##1 !out_crd[p])
            else begin
                $error("release burst has the wrong length");
                record_failure("credit release", `NOC_BUF_DEPTH, out_crd[p]);
            end
    end

endmodule

bind router_two_stage router_chk router_chk_inst (.*);

// File: src/router_two_stage.sv
`include "noc_router_macros.svh"

module router_two_stage (
    input  logic                         clk,
    input  logic                         arst_n,
    input  noc_router_pkg::router_addr_t router_addr,
    input  noc_router_pkg::flit_chan_t   chan_in  [`NOC_PORTS],
    output noc_router_pkg::flit_chan_t   chan_out [`NOC_PORTS],
    input  noc_router_pkg::port_oh_t     credit_release_en
);
    import noc_router_pkg::*;

    port_oh_t              req          [`NOC_PORTS];
    port_oh_t              grant_matrix [`NOC_PORTS];
    flit_t                 iport_flit   [`NOC_PORTS];
    flit_t                 xbar_flit    [`NOC_PORTS];
    logic [`NOC_PORTS-1:0] is_last;
    logic [`NOC_PORTS-1:0] grant;
    logic [`NOC_PORTS-1:0] iport_credit;    // toward upstream routers
    logic [`NOC_PORTS-1:0] release_credit;
    logic [`NOC_PORTS-1:0] oport_credit;    // from downstream routers
    logic [`NOC_PORTS-1:0] xbar_wr;

    for (genvar i = 0; i < `NOC_PORTS; i++) begin : g_port
        input_port #(
            .port_id(port_e'(i))
        ) input_port_inst (
            .clk        (clk),
            .arst_n     (arst_n),
            .router_addr(router_addr),
            .flit_in    (chan_in[i].flit),
            .flit_wr    (chan_in[i].flit_wr),
            .grant      (grant[i]),
            .req        (req[i]),
            .is_last    (is_last[i]),
            .flit_out   (iport_flit[i]),
            .credit     (iport_credit[i])
        );

        // only the local port is expected to see release requests
        credit_release_gen credit_release_gen_inst (
            .clk   (clk),
            .arst_n(arst_n),
            .en    (credit_release_en[i]),
            .credit(release_credit[i])
        );

        assign oport_credit[i]    = chan_in[i].credit;
        assign chan_out[i].flit    = xbar_flit[i];
        assign chan_out[i].flit_wr = xbar_wr[i];
        assign chan_out[i].credit  = iport_credit[i] | release_credit[i];
    end

    // stage one, allocation
    switch_allocator switch_allocator_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .is_last     (is_last),
        .credit_in   (oport_credit),
        .grant       (grant),
        .grant_matrix(grant_matrix)
    );

    // stage two, traversal
    crossbar crossbar_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .grant_matrix(grant_matrix),
        .flit_in     (iport_flit),
        .chan_flit   (xbar_flit),
        .chan_flit_wr(xbar_wr)
    );

endmodule

// File: src/credit_release_gen.sv
`include "noc_router_macros.svh"

module credit_release_gen (
    input  logic clk,
    input  logic arst_n,
    input  logic en,
    output logic credit
);
    localparam logic [`NOC_CRDT_W-1:0] CNT_MAX = `NOC_BUF_DEPTH;

    logic [`NOC_CRDT_W-1:0] cnt;
    logic                   cnt_zero;
    logic                   cnt_max;
    logic                   step;

    assign cnt_zero = (cnt == '0);
    assign cnt_max  = (cnt == CNT_MAX);
    // start on en, then run on its own until the max
    assign step     = (en && cnt_zero) || (!cnt_zero && !cnt_max);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt    <= '0;
            credit <= 1'b0;
        end else begin
            if (step) begin
                cnt <= cnt + 1'b1;
            end
            credit <= step;  // one credit per counted step, stays at max
        end
    end

endmodule

// File: src/crossbar.sv
`include "noc_router_macros.svh"

module crossbar (
    input  logic                     clk,
    input  logic                     arst_n,
    input  noc_router_pkg::port_oh_t grant_matrix [`NOC_PORTS],
    input  noc_router_pkg::flit_t    flit_in      [`NOC_PORTS],
    output noc_router_pkg::flit_t    chan_flit    [`NOC_PORTS],
    output logic [`NOC_PORTS-1:0]    chan_flit_wr
);
    import noc_router_pkg::*;

    port_oh_t grant_q [`NOC_PORTS];   // row per output, bit per input
    flit_t    flit_q  [`NOC_PORTS];   // popped flit per input

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int o = 0; o < `NOC_PORTS; o++) begin
                grant_q[o] <= '0;
            end
        end else begin
            grant_q <= grant_matrix;
        end
    end

    always_ff @(posedge clk) begin
        flit_q <= flit_in;
    end

    // and-or mux, grant rows are one-hot or empty
    always_comb begin : mux
        logic [$bits(flit_t)-1:0] sel;
        for (int o = 0; o < `NOC_PORTS; o++) begin
            sel = '0;
            for (int i = 0; i < `NOC_PORTS; i++) begin
                if (grant_q[o][i]) begin
                    sel |= flit_q[i];
                end
            end
            chan_flit[o]    = flit_t'(sel);
            chan_flit_wr[o] = |grant_q[o];
        end
    end

endmodule

// File: src/switch_allocator.sv
`include "noc_router_macros.svh"

module switch_allocator (
    input  logic                     clk,
    input  logic                     arst_n,
    input  noc_router_pkg::port_oh_t req          [`NOC_PORTS],
    input  logic [`NOC_PORTS-1:0]    is_last,
    input  logic [`NOC_PORTS-1:0]    credit_in,
    output logic [`NOC_PORTS-1:0]    grant,
    output noc_router_pkg::port_oh_t grant_matrix [`NOC_PORTS]
);
    import noc_router_pkg::*;

    localparam int                     IDX_W     = $clog2(`NOC_PORTS);
    localparam logic [`NOC_CRDT_W-1:0] CRDT_INIT = `NOC_BUF_DEPTH;

    // rotating priority, search starts just after the last winner
    function automatic port_oh_t rr_pick(port_oh_t cand, logic [IDX_W-1:0] last);
        port_oh_t pick;
        int       idx;
        pick = '0;
        for (int k = 1; k <= `NOC_PORTS; k++) begin
            idx = (int'(last) + k) % `NOC_PORTS;
            if (cand[idx] && pick == '0) begin
                pick[idx] = 1'b1;
            end
        end
        return pick;
    endfunction

    for (genvar o = 0; o < `NOC_PORTS; o++) begin : g_out
        port_oh_t               col;            // inputs asking for this output
        port_oh_t               cand;
        port_oh_t               lock_owner;
        logic                   locked;
        logic [IDX_W-1:0]       last_q;
        logic [IDX_W-1:0]       win_idx;
        logic [`NOC_CRDT_W-1:0] crdt_q;         // free slots downstream
        logic                   granted;
        logic                   win_is_last;

        always_comb begin
            for (int i = 0; i < `NOC_PORTS; i++) begin
                col[i] = req[i][o];
            end
        end

        // a locked output serves only the packet holding it
        assign cand            = locked ? (col & lock_owner) : rr_pick(col, last_q);
        assign grant_matrix[o] = (crdt_q != '0) ? cand : '0;
        assign granted         = |grant_matrix[o];
        assign win_is_last     = |(grant_matrix[o] & is_last);

        always_comb begin
            win_idx = last_q;
            for (int i = 0; i < `NOC_PORTS; i++) begin
                if (grant_matrix[o][i]) begin
                    win_idx = IDX_W'(i);
                end
            end
        end

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                locked     <= 1'b0;
                lock_owner <= '0;
                last_q     <= '0;
                crdt_q     <= CRDT_INIT;
            end else begin
                if (granted) begin
                    // held from head to tail, single flits never lock
                    locked     <= !win_is_last;
                    lock_owner <= grant_matrix[o];
                    last_q     <= win_idx;
                end
                case ({credit_in[o], granted})
                    2'b10:   crdt_q <= crdt_q + 1'b1;
                    2'b01:   crdt_q <= crdt_q - 1'b1;
                    default: ;  // both or neither
                endcase
            end
        end
    end

    // each input asks for one output, so at most one column bit is set
    always_comb begin
        grant = '0;
        for (int o = 0; o < `NOC_PORTS; o++) begin
            grant |= grant_matrix[o];
        end
    end

endmodule

// File: src/input_port.sv
`include "noc_router_macros.svh"

module input_port #(
    parameter noc_router_pkg::port_e port_id = noc_router_pkg::LOCAL
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  noc_router_pkg::router_addr_t router_addr,
    input  noc_router_pkg::flit_t        flit_in,
    input  logic                         flit_wr,
    input  logic                         grant,
    output noc_router_pkg::port_oh_t     req,
    output logic                         is_last,
    output noc_router_pkg::flit_t        flit_out,
    output logic                         credit
);
    import noc_router_pkg::*;

    localparam int               PTR_W    = $clog2(`NOC_BUF_DEPTH);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`NOC_BUF_DEPTH - 1);

    flit_t                  mem [`NOC_BUF_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [`NOC_CRDT_W-1:0] count;
    logic                   empty;
    logic                   front_is_head;
    port_e                  xy_port;
    port_e                  route_q;        // output taken by the current packet
    port_e                  route;

    assign flit_out      = mem[rd_ptr];
    assign empty         = (count == '0);
    assign front_is_head = flit_out.flit_type inside {HEAD, SINGLE};
    assign is_last       = !empty && (flit_out.flit_type inside {TAIL, SINGLE});

    // dimension order routing, x first then y
    always_comb begin
        if (flit_out.dst.x > router_addr.x) begin
            xy_port = EAST;
        end else if (flit_out.dst.x < router_addr.x) begin
            xy_port = WEST;
        end else if (flit_out.dst.y > router_addr.y) begin
            xy_port = NORTH;
        end else if (flit_out.dst.y < router_addr.y) begin
            xy_port = SOUTH;
        end else begin
            xy_port = LOCAL;    // arrived
        end
    end

    // body and tail flits follow their head
    assign route = front_is_head ? xy_port : route_q;
    assign req   = empty ? '0 : (port_oh_t'(1) << route);

    always_ff @(posedge clk) begin
        if (flit_wr) begin
            mem[wr_ptr] <= flit_in;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            route_q <= port_id;  // no packet seen yet
            credit  <= 1'b0;
        end else begin
            if (flit_wr) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (grant) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({flit_wr, grant})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            if (grant && front_is_head) begin
                route_q <= xy_port;
            end
            // slot freed at this edge, tell the upstream router
            credit <= grant;
        end
    end

endmodule

// File: src/noc_router_pkg.sv
`include "noc_router_macros.svh"

package noc_router_pkg;

    // port numbering of the mesh router, local first
    typedef enum logic [2:0] {
        LOCAL = 3'd0,
        EAST  = 3'd1,
        NORTH = 3'd2,
        WEST  = 3'd3,
        SOUTH = 3'd4
    } port_e;

    typedef enum logic [1:0] {
        HEAD   = 2'd0,
        BODY   = 2'd1,
        TAIL   = 2'd2,
        SINGLE = 2'd3   // head and tail in one flit
    } flit_type_e;

    typedef struct packed {
        logic [`NOC_COORD_W-1:0] x;
        logic [`NOC_COORD_W-1:0] y;
    } router_addr_t;

    typedef struct packed {
        flit_type_e                flit_type;
        router_addr_t              dst;       // only valid in head and single flits
        logic [`NOC_PAYLOAD_W-1:0] payload;
    } flit_t;

    // one direction of one link
    typedef struct packed {
        flit_t flit;
        logic  flit_wr;
        logic  credit;
    } flit_chan_t;

    // one bit per router port, used for requests and grants
    typedef logic [`NOC_PORTS-1:0] port_oh_t;

endpackage

// File: src/noc_router_macros.svh
`ifndef NOC_ROUTER_MACROS_SVH
`define NOC_ROUTER_MACROS_SVH

// local port plus the four mesh directions
`define NOC_PORTS 5

// flits per input buffer
// also the reset credit count and the release burst length
`define NOC_BUF_DEPTH 4

// bits per mesh coordinate
`define NOC_COORD_W 3

`define NOC_PAYLOAD_W 16

// wide enough to hold NOC_BUF_DEPTH itself
`define NOC_CRDT_W 3

`endif
